//--- design/ooo_pkg.sv
package ooo_pkg;

  // ------------------------------
  // architectural register space
  // ------------------------------
  localparam int ARCH_REGS  = 32;
  localparam int ARCH_REG_W = 5;

  typedef logic [ARCH_REG_W-1:0] arch_reg_t;

  // ------------------------------
  // reorder buffer entry lifecycle
  // ------------------------------
  // empty slots also mark the unused lanes of a partial group
  typedef enum logic [1:0] {
    ENTRY_EMPTY   = 2'd0,
    ENTRY_WAITING = 2'd1,
    ENTRY_DONE    = 2'd2
  } entry_state_t;

endpackage

//--- design/rename_alloc.sv
`timescale 1ns/1ps

module rename_alloc import ooo_pkg::*; #(
  parameter int  DISPATCH_WIDTH = 2,
  parameter int  PHYS_REGS      = 48,
  localparam int PHYS_W         = $clog2(PHYS_REGS)
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic      [DISPATCH_WIDTH-1:0]             dispatch_valid,
  input  arch_reg_t [DISPATCH_WIDTH-1:0]             dispatch_arch_rd,
  input  logic                                  dispatch_stall,
  input  logic      [DISPATCH_WIDTH-1:0]             free_valid,
  input  logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] free_phys,
  output logic                                  alloc_fire,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_phys_rd,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_prev_phys,
  output logic                                  free_short
);

  localparam int CNT_W     = PHYS_W + 1;
  localparam int INIT_FREE = PHYS_REGS - ARCH_REGS;

  logic [PHYS_W-1:0] free_mem [PHYS_REGS];
  logic [PHYS_W-1:0] fl_head;
  logic [PHYS_W-1:0] fl_tail;
  logic [CNT_W-1:0]  fl_count;
  logic [CNT_W-1:0]  pop_count;
  logic [CNT_W-1:0]  push_count;
  logic [DISPATCH_WIDTH-1:0][PHYS_W-1:0] push_idx;

  logic [PHYS_W-1:0] spec_map [ARCH_REGS];

  // circular pointer step, the list is not a power of two deep
  function automatic logic [PHYS_W-1:0] ptr_add(input logic [PHYS_W-1:0] ptr,
                                                input logic [CNT_W-1:0]  n);
    int unsigned sum;
    sum = int'(ptr) + int'(n);
    if (sum >= PHYS_REGS) begin
      sum = sum - PHYS_REGS;
    end
    return PHYS_W'(sum);
  endfunction

  assign alloc_fire = (|dispatch_valid) && !dispatch_stall;
  assign free_short = fl_count < CNT_W'(DISPATCH_WIDTH);

  // ------------------------------
  // pop side
  // ------------------------------
  // valid slots take consecutive entries from the head, lowest slot first
  always_comb begin
    pop_count = '0;
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      alloc_phys_rd[s] = free_mem[ptr_add(fl_head, pop_count)];
      if (dispatch_valid[s]) begin
        pop_count = pop_count + 1'b1;
      end
    end
  end

  // previous mapping, forwarded from a lower slot writing the same register
  always_comb begin
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      alloc_prev_phys[s] = spec_map[dispatch_arch_rd[s]];
      for (int t = 0; t < s; t++) begin
        if (dispatch_valid[t] && dispatch_arch_rd[t] == dispatch_arch_rd[s]) begin
          alloc_prev_phys[s] = alloc_phys_rd[t];
        end
      end
    end
  end

  // ------------------------------
  // push side
  // ------------------------------
  always_comb begin
    push_count = '0;
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      push_idx[s] = ptr_add(fl_tail, push_count);
      if (free_valid[s]) begin
        push_count = push_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fl_head  <= '0;
      fl_tail  <= PHYS_W'(INIT_FREE);
      fl_count <= CNT_W'(INIT_FREE);
    end else begin
      if (alloc_fire) begin
        fl_head <= ptr_add(fl_head, pop_count);
      end
      fl_tail  <= ptr_add(fl_tail, push_count);
      fl_count <= fl_count + push_count - (alloc_fire ? pop_count : CNT_W'(0));
    end
  end

  // registers above the architectural range start out free, in order
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < INIT_FREE; i++) begin
        free_mem[i] <= PHYS_W'(ARCH_REGS + i);
      end
    end else begin
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        if (free_valid[s]) begin
          free_mem[push_idx[s]] <= free_phys[s];
        end
      end
    end
  end

  // ------------------------------
  // speculative map
  // ------------------------------
  // higher slot wins when a group names one register twice
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        spec_map[r] <= PHYS_W'(r);
      end
    end else if (alloc_fire) begin
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        if (dispatch_valid[s]) begin
          spec_map[dispatch_arch_rd[s]] <= alloc_phys_rd[s];
        end
      end
    end
  end

  // stall from the buffer must keep the list from running dry
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    alloc_fire |-> pop_count <= fl_count)
    else $error("free list underflow on dispatch");

endmodule

//--- design/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; #(
  parameter int  DISPATCH_WIDTH = 2,
  parameter int  ROB_DEPTH      = 8,
  parameter int  PHYS_REGS      = 48,
  localparam int PHYS_W         = $clog2(PHYS_REGS),
  localparam int ROW_W          = $clog2(ROB_DEPTH),
  localparam int BANK_W         = (DISPATCH_WIDTH > 1) ? $clog2(DISPATCH_WIDTH) : 1
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic      [DISPATCH_WIDTH-1:0]             dispatch_valid,
  input  arch_reg_t [DISPATCH_WIDTH-1:0]             dispatch_arch_rd,
  input  logic                                       alloc_fire,
  input  logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_phys_rd,
  input  logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_prev_phys,
  input  logic      [DISPATCH_WIDTH-1:0]             wb_valid,
  input  logic      [DISPATCH_WIDTH-1:0][ROW_W-1:0]  wb_row,
  input  logic      [DISPATCH_WIDTH-1:0][BANK_W-1:0] wb_bank,
  input  logic                                       free_short,
  output logic                                       dispatch_stall,
  output logic                                       dispatch_ack,
  output logic      [ROW_W-1:0]                      dispatch_rob_row,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] dispatch_phys_rd,
  output logic      [DISPATCH_WIDTH-1:0]             ret_valid,
  output arch_reg_t [DISPATCH_WIDTH-1:0]             ret_arch_rd,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] ret_phys_rd,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] ret_prev_phys
);

  entry_state_t      ent_state [ROB_DEPTH][DISPATCH_WIDTH];
  arch_reg_t         ent_arch  [ROB_DEPTH][DISPATCH_WIDTH];
  logic [PHYS_W-1:0] ent_phys  [ROB_DEPTH][DISPATCH_WIDTH];
  logic [PHYS_W-1:0] ent_prev  [ROB_DEPTH][DISPATCH_WIDTH];

  logic [ROW_W-1:0] tail_row;
  logic [ROW_W-1:0] head_row;
  logic [ROW_W:0]   row_count;

  logic                      head_ready;
  logic [DISPATCH_WIDTH-1:0] head_mask;

  assign dispatch_stall = (row_count == (ROW_W + 1)'(ROB_DEPTH)) || free_short;

  // ------------------------------
  // head row readiness
  // ------------------------------
  // needs one occupied slot, and every occupied slot done
  always_comb begin
    head_ready = 1'b1;
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      head_mask[s] = ent_state[head_row][s] != ENTRY_EMPTY;
      if (head_mask[s] && ent_state[head_row][s] != ENTRY_DONE) begin
        head_ready = 1'b0;
      end
    end
    if (head_mask == '0) begin
      head_ready = 1'b0;
    end
  end

  // ------------------------------
  // entry state
  // ------------------------------
  // commit, dispatch and writeback never meet on one entry
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ROB_DEPTH; r++) begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
          ent_state[r][s] <= ENTRY_EMPTY;
        end
      end
    end else begin
      if (head_ready) begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
          ent_state[head_row][s] <= ENTRY_EMPTY;
        end
      end
      if (alloc_fire) begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
          if (dispatch_valid[s]) begin
            ent_state[tail_row][s] <= ENTRY_WAITING;
          end else begin
            ent_state[tail_row][s] <= ENTRY_EMPTY;
          end
        end
      end
      for (int l = 0; l < DISPATCH_WIDTH; l++) begin
        if (wb_valid[l]) begin
          ent_state[wb_row[l]][wb_bank[l]] <= ENTRY_DONE;
        end
      end
    end
  end

  // entry payload and response data
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      dispatch_rob_row <= tail_row;
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        ent_arch[tail_row][s]  <= dispatch_arch_rd[s];
        ent_phys[tail_row][s]  <= alloc_phys_rd[s];
        ent_prev[tail_row][s]  <= alloc_prev_phys[s];
        dispatch_phys_rd[s]    <= dispatch_valid[s] ? alloc_phys_rd[s] : '0;
      end
    end
    if (head_ready) begin
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        ret_arch_rd[s]   <= ent_arch[head_row][s];
        ret_phys_rd[s]   <= ent_phys[head_row][s];
        ret_prev_phys[s] <= ent_prev[head_row][s];
      end
    end
  end

  // ------------------------------
  // row pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_row     <= '0;
      head_row     <= '0;
      row_count    <= '0;
      dispatch_ack <= 1'b0;
      ret_valid    <= '0;
    end else begin
      dispatch_ack <= alloc_fire;
      ret_valid    <= head_ready ? head_mask : '0;
      if (alloc_fire) begin
        tail_row <= tail_row + 1'b1;
      end
      if (head_ready) begin
        head_row <= head_row + 1'b1;
      end
      case ({alloc_fire, head_ready})
        2'b10:   row_count <= row_count + 1'b1;
        2'b01:   row_count <= row_count - 1'b1;
        default: row_count <= row_count;
      endcase
    end
  end

  // writeback lanes come from outside and must hit a live entry
  for (genvar l = 0; l < DISPATCH_WIDTH; l++) begin : g_wb_check
    a_wb_waiting: assert property (@(posedge clk) disable iff (rst)
      wb_valid[l] |-> ent_state[wb_row[l]][wb_bank[l]] == ENTRY_WAITING)
      else $error("writeback to an entry that is not waiting");
  end

  a_no_fire_stalled: assert property (@(posedge clk) disable iff (rst)
    alloc_fire |-> !dispatch_stall)
    else $error("dispatch accepted while stalled");

endmodule

//--- design/retire_map.sv
`timescale 1ns/1ps

module retire_map import ooo_pkg::*; #(
  parameter int  DISPATCH_WIDTH = 2,
  parameter int  PHYS_REGS      = 48,
  localparam int PHYS_W         = $clog2(PHYS_REGS)
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic      [DISPATCH_WIDTH-1:0]             ret_valid,
  input  arch_reg_t [DISPATCH_WIDTH-1:0]             ret_arch_rd,
  input  logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] ret_phys_rd,
  input  logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] ret_prev_phys,
  input  arch_reg_t                                  query_arch,
  output logic      [PHYS_W-1:0]                     query_phys,
  output logic      [DISPATCH_WIDTH-1:0]             free_valid,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] free_phys
);

  logic [PHYS_W-1:0] commit_map [ARCH_REGS];
  logic              free_hits_map;

  assign query_phys = commit_map[query_arch];

  // committed map, later slot overwrites earlier on the same register
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        commit_map[r] <= PHYS_W'(r);
      end
    end else begin
      for (int s = 0; s < DISPATCH_WIDTH; s++) begin
        if (ret_valid[s]) begin
          commit_map[ret_arch_rd[s]] <= ret_phys_rd[s];
        end
      end
    end
  end

  // ------------------------------
  // free returns
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      free_valid <= '0;
    end else begin
      free_valid <= ret_valid;
    end
  end

  always_ff @(posedge clk) begin
    free_phys <= ret_prev_phys;
  end

  // a freed register must already be gone from the updated map
  always_comb begin
    free_hits_map = 1'b0;
    for (int s = 0; s < DISPATCH_WIDTH; s++) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        if (free_valid[s] && commit_map[r] == free_phys[s]) begin
          free_hits_map = 1'b1;
        end
      end
    end
  end

  a_free_unmapped: assert property (@(posedge clk) disable iff (rst) !free_hits_map)
    else $error("returned register is still committed in the map");

endmodule

//--- design/ooo_backend_top.sv
`timescale 1ns/1ps

module ooo_backend_top import ooo_pkg::*; #(
  parameter int  DISPATCH_WIDTH = 2,
  parameter int  ROB_DEPTH      = 8,
  parameter int  PHYS_REGS      = 48,
  localparam int PHYS_W         = $clog2(PHYS_REGS),
  localparam int ROW_W          = $clog2(ROB_DEPTH),
  localparam int BANK_W         = (DISPATCH_WIDTH > 1) ? $clog2(DISPATCH_WIDTH) : 1
) (
  input  logic                                       clk,
  input  logic                                       rst,
  // dispatch
  input  logic      [DISPATCH_WIDTH-1:0]             dispatch_valid,
  input  arch_reg_t [DISPATCH_WIDTH-1:0]             dispatch_arch_rd,
  output logic                                       dispatch_stall,
  output logic                                       dispatch_ack,
  output logic      [ROW_W-1:0]                      dispatch_rob_row,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] dispatch_phys_rd,
  // writeback lanes
  input  logic      [DISPATCH_WIDTH-1:0]             wb_valid,
  input  logic      [DISPATCH_WIDTH-1:0][ROW_W-1:0]  wb_row,
  input  logic      [DISPATCH_WIDTH-1:0][BANK_W-1:0] wb_bank,
  // commit
  output logic      [DISPATCH_WIDTH-1:0]             commit_valid,
  output arch_reg_t [DISPATCH_WIDTH-1:0]             commit_arch_rd,
  output logic      [DISPATCH_WIDTH-1:0][PHYS_W-1:0] commit_phys_rd,
  // committed map lookup
  input  arch_reg_t                                  query_arch,
  output logic      [PHYS_W-1:0]                     query_phys
);

  // dispatch accept condition, shared by allocator and buffer
  logic alloc_fire;
  logic free_short;

  logic [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_phys_rd;
  logic [DISPATCH_WIDTH-1:0][PHYS_W-1:0] alloc_prev_phys;
  logic [DISPATCH_WIDTH-1:0][PHYS_W-1:0] ret_prev_phys;
  logic [DISPATCH_WIDTH-1:0]             free_valid;
  logic [DISPATCH_WIDTH-1:0][PHYS_W-1:0] free_phys;

  rename_alloc #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PHYS_REGS      (PHYS_REGS)
  ) u_rename (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_arch_rd (dispatch_arch_rd),
    .dispatch_stall   (dispatch_stall),
    .free_valid       (free_valid),
    .free_phys        (free_phys),
    .alloc_fire       (alloc_fire),
    .alloc_phys_rd    (alloc_phys_rd),
    .alloc_prev_phys  (alloc_prev_phys),
    .free_short       (free_short)
  );

  // commit outputs double as the retirement pulses
  reorder_buffer #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .ROB_DEPTH      (ROB_DEPTH),
    .PHYS_REGS      (PHYS_REGS)
  ) u_rob (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_arch_rd (dispatch_arch_rd),
    .alloc_fire       (alloc_fire),
    .alloc_phys_rd    (alloc_phys_rd),
    .alloc_prev_phys  (alloc_prev_phys),
    .wb_valid         (wb_valid),
    .wb_row           (wb_row),
    .wb_bank          (wb_bank),
    .free_short       (free_short),
    .dispatch_stall   (dispatch_stall),
    .dispatch_ack     (dispatch_ack),
    .dispatch_rob_row (dispatch_rob_row),
    .dispatch_phys_rd (dispatch_phys_rd),
    .ret_valid        (commit_valid),
    .ret_arch_rd      (commit_arch_rd),
    .ret_phys_rd      (commit_phys_rd),
    .ret_prev_phys    (ret_prev_phys)
  );

  retire_map #(
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .PHYS_REGS      (PHYS_REGS)
  ) u_retire (
    .clk           (clk),
    .rst           (rst),
    .ret_valid     (commit_valid),
    .ret_arch_rd   (commit_arch_rd),
    .ret_phys_rd   (commit_phys_rd),
    .ret_prev_phys (ret_prev_phys),
    .query_arch    (query_arch),
    .query_phys    (query_phys),
    .free_valid    (free_valid),
    .free_phys     (free_phys)
  );

endmodule

//--- verif/tb_ooo_backend.sv
`timescale 1ns/1ps

module tb_ooo_backend import ooo_pkg::*; ();

  localparam int DW             = 2;
  localparam int ROB_DEPTH      = 8;
  localparam int PHYS_REGS      = 48;
  localparam int PHYS_W         = $clog2(PHYS_REGS);
  localparam int ROW_W          = $clog2(ROB_DEPTH);
  localparam int BANK_W         = (DW > 1) ? $clog2(DW) : 1;
  localparam int ACK_TIMEOUT    = 40;
  localparam int COMMIT_TIMEOUT = 20;
  localparam int STALL_HOLD     = 6;

  logic                             clk;
  logic                             rst;
  logic      [DW-1:0]               dispatch_valid;
  arch_reg_t [DW-1:0]               dispatch_arch_rd;
  logic                             dispatch_stall;
  logic                             dispatch_ack;
  logic      [ROW_W-1:0]            dispatch_rob_row;
  logic      [DW-1:0][PHYS_W-1:0]   dispatch_phys_rd;
  logic      [DW-1:0]               wb_valid;
  logic      [DW-1:0][ROW_W-1:0]    wb_row;
  logic      [DW-1:0][BANK_W-1:0]   wb_bank;
  logic      [DW-1:0]               commit_valid;
  arch_reg_t [DW-1:0]               commit_arch_rd;
  logic      [DW-1:0][PHYS_W-1:0]   commit_phys_rd;
  arch_reg_t                        query_arch;
  logic      [PHYS_W-1:0]           query_phys;

  // ------------------------------
  // reference model state
  // ------------------------------
  logic [PHYS_W-1:0] free_q [$];
  logic [PHYS_W-1:0] spec_map [ARCH_REGS];
  logic [PHYS_W-1:0] commit_map [ARCH_REGS];
  logic [DW-1:0]     m_valid [ROB_DEPTH];
  logic [DW-1:0]     m_done [ROB_DEPTH];
  arch_reg_t         m_arch [ROB_DEPTH][DW];
  logic [PHYS_W-1:0] m_phys [ROB_DEPTH][DW];
  logic [PHYS_W-1:0] m_prev [ROB_DEPTH][DW];
  int                m_head;
  int                m_tail;
  int                m_count;
  int                commit_seen;

  int     errors;
  int     tests_passed;
  int     tests_failed;
  integer seed;

  ooo_backend_top #(
    .DISPATCH_WIDTH (DW),
    .ROB_DEPTH      (ROB_DEPTH),
    .PHYS_REGS      (PHYS_REGS)
  ) u_dut (
    .clk              (clk),
    .rst              (rst),
    .dispatch_valid   (dispatch_valid),
    .dispatch_arch_rd (dispatch_arch_rd),
    .dispatch_stall   (dispatch_stall),
    .dispatch_ack     (dispatch_ack),
    .dispatch_rob_row (dispatch_rob_row),
    .dispatch_phys_rd (dispatch_phys_rd),
    .wb_valid         (wb_valid),
    .wb_row           (wb_row),
    .wb_bank          (wb_bank),
    .commit_valid     (commit_valid),
    .commit_arch_rd   (commit_arch_rd),
    .commit_phys_rd   (commit_phys_rd),
    .query_arch       (query_arch),
    .query_phys       (query_phys)
  );

  always #4 clk = ~clk;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_phys(input string name, input logic [PHYS_W-1:0] exp,
                            input logic [PHYS_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_arch(input string name, input arch_reg_t exp, input arch_reg_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_row(input string name, input logic [ROW_W-1:0] exp,
                           input logic [ROW_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mask(input string name, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail (%0d errors)", name, errors - errors_before);
    end
  endtask

  // ------------------------------
  // model and cycle stepping
  // ------------------------------
  task automatic model_reset();
    free_q.delete();
    for (int p = ARCH_REGS; p < PHYS_REGS; p++) free_q.push_back(PHYS_W'(p));
    for (int r = 0; r < ARCH_REGS; r++) begin
      spec_map[r]   = PHYS_W'(r);
      commit_map[r] = PHYS_W'(r);
    end
    for (int r = 0; r < ROB_DEPTH; r++) begin
      m_valid[r] = '0;
      m_done[r]  = '0;
    end
    m_head      = 0;
    m_tail      = 0;
    m_count     = 0;
    commit_seen = 0;
  endtask

  // oldest row retires and its previous registers join the free list tail
  task automatic handle_commit();
    if (m_count == 0) begin
      report_failure("commit seen while no row was outstanding");
    end else begin
      check_mask("commit_valid", m_valid[m_head], commit_valid);
      if ((m_valid[m_head] & ~m_done[m_head]) != '0) begin
        report_failure("row committed before all its slots were written back");
      end
      for (int s = 0; s < DW; s++) begin
        if (m_valid[m_head][s]) begin
          check_arch($sformatf("commit_arch_rd[%0d]", s), m_arch[m_head][s], commit_arch_rd[s]);
          check_phys($sformatf("commit_phys_rd[%0d]", s), m_phys[m_head][s], commit_phys_rd[s]);
          commit_map[m_arch[m_head][s]] = m_phys[m_head][s];
          free_q.push_back(m_prev[m_head][s]);
        end
      end
      m_valid[m_head] = '0;
      m_done[m_head]  = '0;
      m_head          = (m_head + 1) % ROB_DEPTH;
      m_count--;
    end
    commit_seen++;
  endtask

  // every cycle passes through here so no commit pulse goes unchecked
  task automatic step();
    @(negedge clk);
    if (commit_valid != '0) handle_commit();
  endtask

  task automatic drive_group(input logic [DW-1:0] valid, input arch_reg_t [DW-1:0] arch);
    dispatch_valid   = valid;
    dispatch_arch_rd = arch;
  endtask

  // group is held until ack and then checked and recorded
  task automatic wait_ack();
    logic              got;
    logic [PHYS_W-1:0] exp;
    got = 1'b0;
    for (int i = 0; i < ACK_TIMEOUT && !got; i++) begin
      step();
      got = dispatch_ack;
    end
    if (!got) begin
      report_failure("timeout waiting for dispatch ack");
    end else begin
      check_row("dispatch_rob_row", ROW_W'(m_tail), dispatch_rob_row);
      for (int s = 0; s < DW; s++) begin
        if (dispatch_valid[s]) begin
          if (free_q.size() == 0) begin
            report_failure("dispatch accepted while no free register was expected");
            exp = '0;
          end else begin
            exp = free_q.pop_front();
          end
          check_phys($sformatf("dispatch_phys_rd[%0d]", s), exp, dispatch_phys_rd[s]);
          m_arch[m_tail][s] = dispatch_arch_rd[s];
          m_phys[m_tail][s] = exp;
          m_prev[m_tail][s] = spec_map[dispatch_arch_rd[s]];
          spec_map[dispatch_arch_rd[s]] = exp;
        end
      end
      m_valid[m_tail] = dispatch_valid;
      m_done[m_tail]  = '0;
      m_tail          = (m_tail + 1) % ROB_DEPTH;
      m_count++;
    end
    dispatch_valid = '0;
  endtask

  task automatic writeback_one(input int row, input int slot, input int lane);
    wb_valid[lane] = 1'b1;
    wb_row[lane]   = ROW_W'(row);
    wb_bank[lane]  = BANK_W'(slot);
    m_done[row][slot] = 1'b1;
    step();
    wb_valid = '0;
  endtask

  // lane s carries slot s
  task automatic writeback_row(input int row, input logic [DW-1:0] mask);
    for (int s = 0; s < DW; s++) begin
      wb_valid[s] = mask[s];
      wb_row[s]   = ROW_W'(row);
      wb_bank[s]  = BANK_W'(s);
    end
    m_done[row] = m_done[row] | mask;
    step();
    wb_valid = '0;
  endtask

  task automatic expect_commits(input int n);
    int start;
    start = commit_seen;
    for (int i = 0; i < COMMIT_TIMEOUT * n && commit_seen < start + n; i++) step();
    if (commit_seen < start + n) report_failure("timeout waiting for commit");
  endtask

  task automatic expect_no_commit(input int cycles, input string msg);
    int start;
    start = commit_seen;
    repeat (cycles) step();
    if (commit_seen != start) report_failure(msg);
  endtask

  task automatic drain();
    logic [DW-1:0] pending;
    for (int n = 0; n < ROB_DEPTH && m_count > 0; n++) begin
      pending = m_valid[m_head] & ~m_done[m_head];
      if (pending != '0) writeback_row(m_head, pending);
      expect_commits(1);
    end
  endtask

  task automatic check_query_all();
    for (int r = 0; r < ARCH_REGS; r++) begin
      step();
      query_arch = arch_reg_t'(r);
      #1;
      check_phys($sformatf("query_phys[%0d]", r), commit_map[r], query_phys);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset();
    int e0;
    e0 = errors;
    check_flag("dispatch_stall", 1'b0, dispatch_stall);
    check_flag("dispatch_ack", 1'b0, dispatch_ack);
    check_mask("commit_valid", '0, commit_valid);
    check_query_all();
    report_test("reset state", e0);
  endtask

  task automatic test_single_group();
    int            e0;
    int            c0;
    int            row;
    arch_reg_t [DW-1:0] a;
    e0 = errors;
    a[0] = 5;
    a[1] = 7;
    row  = m_tail;
    drive_group(2'b11, a);
    wait_ack();
    check_row("dispatch_rob_row", '0, dispatch_rob_row);
    check_phys("dispatch_phys_rd[0]", PHYS_W'(32), dispatch_phys_rd[0]);
    check_phys("dispatch_phys_rd[1]", PHYS_W'(33), dispatch_phys_rd[1]);
    writeback_one(row, 0, 1);
    writeback_one(row, 1, 0);
    c0 = commit_seen;
    step();
    if (commit_seen != c0 + 1) report_failure("commit did not follow last writeback by one cycle");
    // partial group with slot 1 empty
    a[0] = 9;
    a[1] = 0;
    row  = m_tail;
    drive_group(2'b01, a);
    wait_ack();
    writeback_row(row, 2'b01);
    expect_commits(1);
    report_test("single group", e0);
  endtask

  task automatic test_in_order();
    int                 e0;
    int                 row_a;
    int                 row_b;
    arch_reg_t [DW-1:0] a;
    e0 = errors;
    a[0]  = 1;
    a[1]  = 2;
    row_a = m_tail;
    drive_group(2'b11, a);
    wait_ack();
    a[0]  = 3;
    a[1]  = 4;
    row_b = m_tail;
    drive_group(2'b11, a);
    wait_ack();
    writeback_row(row_b, 2'b11);
    expect_no_commit(4, "younger row committed before the older row");
    writeback_one(row_a, 0, 0);
    expect_no_commit(4, "row committed with a slot still waiting");
    writeback_one(row_a, 1, 1);
    expect_commits(2);
    report_test("in-order retirement", e0);
  endtask

  task automatic test_full_stall();
    int                 e0;
    logic [DW-1:0]      mask;
    arch_reg_t [DW-1:0] a;
    e0 = errors;
    // the first pass stalls on rows alone and the second also empties the free list
    for (int pass = 0; pass < 2; pass++) begin
      mask = (pass == 0) ? 2'b01 : 2'b11;
      for (int g = 0; g < ROB_DEPTH; g++) begin
        a[0] = arch_reg_t'(8 + 2 * g);
        a[1] = arch_reg_t'(9 + 2 * g);
        drive_group(mask, a);
        wait_ack();
      end
      check_flag("dispatch_stall", 1'b1, dispatch_stall);
      a[0] = arch_reg_t'(8 + 2 * ROB_DEPTH);
      a[1] = arch_reg_t'(9 + 2 * ROB_DEPTH);
      drive_group(2'b11, a);
      for (int i = 0; i < STALL_HOLD; i++) begin
        step();
        check_flag("dispatch_ack", 1'b0, dispatch_ack);
      end
      // held group goes in once the head row retires
      writeback_row(m_head, m_valid[m_head]);
      wait_ack();
      drain();
    end
    report_test("full and stall", e0);
  endtask

  task automatic test_recycle();
    int                 e0;
    arch_reg_t [DW-1:0] a;
    e0 = errors;
    a[0] = 6;
    a[1] = 6;
    drive_group(2'b11, a);
    wait_ack();
    a[0] = 7;
    a[1] = 6;
    drive_group(2'b11, a);
    wait_ack();
    a[0] = 30;
    drive_group(2'b01, a);
    wait_ack();
    drain();
    // registers freed by earlier commits come back out in commit order
    for (int g = 0; g < 3; g++) begin
      a[0] = arch_reg_t'(g);
      a[1] = arch_reg_t'(31 - g);
      drive_group(2'b11, a);
      wait_ack();
    end
    drain();
    check_query_all();
    report_test("register recycling", e0);
  endtask

  task automatic test_random();
    int                 e0;
    int                 r;
    int                 pick;
    int                 prow [$];
    int                 pslot [$];
    logic [DW-1:0]      v;
    arch_reg_t [DW-1:0] a;
    e0 = errors;
    for (int it = 0; it < 80; it++) begin
      if (m_count < ROB_DEPTH && ($random(seed) & 1)) begin
        v = DW'($random(seed));
        if (v == '0) v = 1;
        for (int s = 0; s < DW; s++) a[s] = arch_reg_t'($random(seed));
        drive_group(v, a);
        wait_ack();
      end
      prow.delete();
      pslot.delete();
      for (int k = 0; k < m_count; k++) begin
        r = (m_head + k) % ROB_DEPTH;
        for (int s = 0; s < DW; s++) begin
          if (m_valid[r][s] && !m_done[r][s]) begin
            prow.push_back(r);
            pslot.push_back(s);
          end
        end
      end
      if (prow.size() > 0) begin
        pick = $unsigned($random(seed)) % prow.size();
        writeback_one(prow[pick], pslot[pick], $unsigned($random(seed)) % DW);
      end else begin
        step();
      end
    end
    drain();
    check_query_all();
    report_test("random traffic", e0);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    clk              = 1'b0;
    rst              = 1'b1;
    dispatch_valid   = '0;
    dispatch_arch_rd = '0;
    wb_valid         = '0;
    wb_row           = '0;
    wb_bank          = '0;
    query_arch       = '0;
    seed             = 32'h79d3_f70d;
    errors           = 0;
    tests_passed     = 0;
    tests_failed     = 0;
    model_reset();
    repeat (16) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_single_group();
    test_in_order();
    test_full_stall();
    test_recycle();
    test_random();

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
design/ooo_pkg.sv
design/rename_alloc.sv
design/reorder_buffer.sv
design/retire_map.sv
design/ooo_backend_top.sv
verif/tb_ooo_backend.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - files:
      - design/ooo_pkg.sv
      - design/rename_alloc.sv
      - design/reorder_buffer.sv
      - design/retire_map.sv
      - design/ooo_backend_top.sv
  - target: test
    files:
      - verif/tb_ooo_backend.sv
